/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // --------------------------------------------------
    // address map
    // --------------------------------------------------

    // register block sits at 0x0000 to 0x0007
    localparam logic [23:0] reg_block_sel = 24'h000000;

    // the RAM occupies 0x1000 to 0x10FF
    localparam logic [23:0] ram_block_sel = 24'h000010;

    // value returned at register offset 0
    localparam logic [7:0] reg_block_id = 8'hA5;

    // --------------------------------------------------
    // TCP framing
    // --------------------------------------------------

    // two length bytes followed by four address bytes
    localparam logic [15:0] hdr_bytes = 16'd6;

    // keeps length plus header inside a 16-bit byte count
    localparam logic [15:0] max_frame_len = 16'd65529;

    localparam logic [15:0] reset_run_len = 16'd65535;

    // one bus address, either as a flat word or split into block and offset
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [23:0] blk_sel;
            logic [7:0]  offset;
        } fld;
    } bus_addr_u;

endpackage

`default_nettype wire

/* design/tcp_to_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tcp_to_bus (
    input  wire          BUS_CLK,
    input  wire          BUS_RST,
    input  wire          TCP_RX_WR,
    input  wire  [7:0]   TCP_RX_DATA,
    output logic [15:0]  TCP_RX_WC,
    input  wire          RBCP_ACT,
    input  wire  [31:0]  RBCP_ADDR,
    input  wire  [7:0]   RBCP_WD,
    input  wire          RBCP_WE,
    input  wire          RBCP_RE,
    output logic         RBCP_ACK,
    output logic [7:0]   RBCP_RD,
    output logic         BUS_WR,
    output logic         BUS_RD,
    output logic [31:0]  BUS_ADD,
    inout  wire  [7:0]   BUS_DATA,
    output logic         INVALID
);
    import bus_pkg::*;

    logic [15:0] byte_cnt;
    logic [15:0] frame_len;
    logic [31:0] tcp_addr;
    logic [15:0] ff_run;
    logic        stream_rst;
    logic        last_byte;
    logic        tcp_wr;
    logic        rbcp_wr;
    logic [32:0] frame_end;

    // --------------------------------------------------
    // receive word counter
    // --------------------------------------------------

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST || !TCP_RX_WR) begin
            TCP_RX_WC <= '0;
        end else begin
            TCP_RX_WC <= TCP_RX_WC + 16'd1;
        end
    end

    // --------------------------------------------------
    // frame parser
    // --------------------------------------------------

    // true while the final byte of the current frame is on the input
    assign last_byte = (byte_cnt >= hdr_bytes - 16'd1) &&
                       (byte_cnt - (hdr_bytes - 16'd1) == frame_len);

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST || INVALID || stream_rst) begin
            byte_cnt <= '0;
        end else if (TCP_RX_WR) begin
            byte_cnt <= last_byte ? 16'd0 : byte_cnt + 16'd1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            frame_len <= '0;
        end else if (TCP_RX_WR && byte_cnt == 16'd0) begin
            frame_len[7:0] <= TCP_RX_DATA;
        end else if (TCP_RX_WR && byte_cnt == 16'd1) begin
            frame_len[15:8] <= TCP_RX_DATA;
        end
    end

    // the start address is complete before the first payload byte
    always_ff @(posedge BUS_CLK) begin
        if (tcp_wr) begin
            tcp_addr <= tcp_addr + 32'd1;
        end else if (TCP_RX_WR) begin
            case (byte_cnt)
                16'd2:   tcp_addr[7:0]   <= TCP_RX_DATA;
                16'd3:   tcp_addr[15:8]  <= TCP_RX_DATA;
                16'd4:   tcp_addr[23:16] <= TCP_RX_DATA;
                16'd5:   tcp_addr[31:24] <= TCP_RX_DATA;
                default: tcp_addr        <= tcp_addr;
            endcase
        end
    end

    // last address of the frame plus one, in 33 bits
    assign frame_end = {17'd0, frame_len} + {1'b0, TCP_RX_DATA, tcp_addr[23:0]};

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST || stream_rst) begin
            INVALID <= 1'b0;
        end else if (TCP_RX_WR && byte_cnt == 16'd1 &&
                     {TCP_RX_DATA, frame_len[7:0]} > max_frame_len) begin
            INVALID <= 1'b1;
        end else if (TCP_RX_WR && byte_cnt == 16'd5 && frame_end > 33'h1_0000_0000) begin
            INVALID <= 1'b1;
        end
    end

    // --------------------------------------------------
    // stream reset on a long run of 0xFF
    // --------------------------------------------------

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ff_run <= '0;
        end else if (TCP_RX_WR && TCP_RX_DATA != 8'hFF) begin
            ff_run <= '0;
        end else if (TCP_RX_WR && ff_run != reset_run_len - 16'd1) begin
            ff_run <= ff_run + 16'd1;
        end
    end

    // the counter saturates so any further 0xFF keeps the parser cleared
    assign stream_rst = TCP_RX_WR && TCP_RX_DATA == 8'hFF &&
                        ff_run == reset_run_len - 16'd1;

    // --------------------------------------------------
    // bus arbitration, TCP writes win
    // --------------------------------------------------

    assign tcp_wr  = TCP_RX_WR && byte_cnt >= hdr_bytes && !INVALID;
    assign rbcp_wr = RBCP_ACT && RBCP_WE;

    assign BUS_WR   = tcp_wr || rbcp_wr;
    assign BUS_RD   = RBCP_ACT && RBCP_RE && !BUS_WR;
    assign BUS_ADD  = tcp_wr ? tcp_addr : RBCP_ADDR;
    assign BUS_DATA = BUS_WR ? (tcp_wr ? TCP_RX_DATA : RBCP_WD) : 8'hzz;
    assign RBCP_RD  = BUS_RD ? BUS_DATA : 8'h00;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST || RBCP_ACK) begin
            RBCP_ACK <= 1'b0;
        end else begin
            RBCP_ACK <= RBCP_ACT && (RBCP_WE || RBCP_RE) && !tcp_wr;
        end
    end

endmodule

`default_nettype wire

/* design/bus_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_reg_file (
    input wire                    BUS_CLK,
    input wire                    BUS_RST,
    input wire                    BUS_WR,
    input wire                    BUS_RD,
    input wire bus_pkg::bus_addr_u BUS_ADD,
    inout wire [7:0]              BUS_DATA
);
    import bus_pkg::*;

    logic [7:0] scratch [1:6];
    logic [7:0] wr_count;
    logic [7:0] rd_data;
    logic [2:0] reg_idx;
    logic       reg_hit;

    // only the lowest eight offsets of the block are decoded
    assign reg_hit = BUS_ADD.fld.blk_sel == reg_block_sel && BUS_ADD.fld.offset[7:3] == 5'd0;
    assign reg_idx = BUS_ADD.word[2:0];

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            for (int i = 1; i <= 6; i++) begin
                scratch[i] <= '0;
            end
        end else if (BUS_WR && reg_hit && reg_idx != 3'd0 && reg_idx != 3'd7) begin
            scratch[reg_idx] <= BUS_DATA;
        end
    end

    // every write into the block counts, including the read-only offsets
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            wr_count <= '0;
        end else if (BUS_WR && reg_hit) begin
            wr_count <= wr_count + 8'd1;
        end
    end

    always_comb begin
        case (reg_idx)
            3'd0:    rd_data = reg_block_id;
            3'd7:    rd_data = wr_count;
            default: rd_data = scratch[reg_idx];
        endcase
    end

    assign BUS_DATA = (BUS_RD && reg_hit) ? rd_data : 8'hzz;

endmodule

`default_nettype wire

/* design/bus_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_ram (
    input wire                    BUS_CLK,
    input wire                    BUS_WR,
    input wire                    BUS_RD,
    input wire bus_pkg::bus_addr_u BUS_ADD,
    inout wire [7:0]              BUS_DATA
);
    import bus_pkg::*;

    logic [7:0] mem [256];
    logic [7:0] ram_idx;
    logic       ram_hit;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------

    // the whole 256-byte block belongs to this RAM
    assign ram_hit = BUS_ADD.fld.blk_sel == ram_block_sel;
    assign ram_idx = BUS_ADD.fld.offset;

    // --------------------------------------------------
    // storage
    // --------------------------------------------------

    always_ff @(posedge BUS_CLK) begin
        if (BUS_WR && ram_hit) begin
            mem[ram_idx] <= BUS_DATA;
        end
    end

    // reads return the addressed byte within the same cycle
    assign BUS_DATA = (BUS_RD && ram_hit) ? mem[ram_idx] : 8'hzz;

endmodule

`default_nettype wire

/* design/bus_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_subsystem (
    input  wire          BUS_CLK,
    input  wire          BUS_RST,
    input  wire          TCP_RX_WR,
    input  wire  [7:0]   TCP_RX_DATA,
    output wire  [15:0]  TCP_RX_WC,
    input  wire          RBCP_ACT,
    input  wire  [31:0]  RBCP_ADDR,
    input  wire  [7:0]   RBCP_WD,
    input  wire          RBCP_WE,
    input  wire          RBCP_RE,
    output wire          RBCP_ACK,
    output wire  [7:0]   RBCP_RD,
    output wire          INVALID
);

    // --------------------------------------------------
    // shared local bus
    // --------------------------------------------------

    wire        bus_wr;
    wire        bus_rd;
    wire [31:0] bus_add;
    // the bridge drives this on writes and the selected slave on reads
    wire [7:0]  bus_data;

    tcp_to_bus u_bridge (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .TCP_RX_WR   (TCP_RX_WR),
        .TCP_RX_DATA (TCP_RX_DATA),
        .TCP_RX_WC   (TCP_RX_WC),
        .RBCP_ACT    (RBCP_ACT),
        .RBCP_ADDR   (RBCP_ADDR),
        .RBCP_WD     (RBCP_WD),
        .RBCP_WE     (RBCP_WE),
        .RBCP_RE     (RBCP_RE),
        .RBCP_ACK    (RBCP_ACK),
        .RBCP_RD     (RBCP_RD),
        .BUS_WR      (bus_wr),
        .BUS_RD      (bus_rd),
        .BUS_ADD     (bus_add),
        .BUS_DATA    (bus_data),
        .INVALID     (INVALID)
    );

    bus_reg_file u_regs (
        .BUS_CLK  (BUS_CLK),
        .BUS_RST  (BUS_RST),
        .BUS_WR   (bus_wr),
        .BUS_RD   (bus_rd),
        .BUS_ADD  (bus_add),
        .BUS_DATA (bus_data)
    );

    bus_ram u_ram (
        .BUS_CLK  (BUS_CLK),
        .BUS_WR   (bus_wr),
        .BUS_RD   (bus_rd),
        .BUS_ADD  (bus_add),
        .BUS_DATA (bus_data)
    );

endmodule

`default_nettype wire

/* tests/tb_bus_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bus_subsystem;
    import bus_pkg::*;

    localparam string stim_path = "tests/bus_stim.txt";

    logic        BUS_CLK;
    logic        BUS_RST;
    logic        TCP_RX_WR;
    logic [7:0]  TCP_RX_DATA;
    logic        RBCP_ACT;
    logic [31:0] RBCP_ADDR;
    logic [7:0]  RBCP_WD;
    logic        RBCP_WE;
    logic        RBCP_RE;
    wire  [15:0] TCP_RX_WC;
    wire         RBCP_ACK;
    wire  [7:0]  RBCP_RD;
    wire         INVALID;

    // expected RAM contents, filled in as valid frames are sent
    logic [7:0]  ram_model [256];
    longint      total_cycles;
    bit          watchdog_armed;

    bus_subsystem DUT (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .TCP_RX_WR   (TCP_RX_WR),
        .TCP_RX_DATA (TCP_RX_DATA),
        .TCP_RX_WC   (TCP_RX_WC),
        .RBCP_ACT    (RBCP_ACT),
        .RBCP_ADDR   (RBCP_ADDR),
        .RBCP_WD     (RBCP_WD),
        .RBCP_WE     (RBCP_WE),
        .RBCP_RE     (RBCP_RE),
        .RBCP_ACK    (RBCP_ACK),
        .RBCP_RD     (RBCP_RD),
        .INVALID     (INVALID)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #10 BUS_CLK = ~BUS_CLK;
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    task automatic fail_stop();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input bus_pkg::bus_addr_u addr, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: read of %h (block %h offset %h) gave %h, expected %h",
                     $time, addr.word, addr.fld.blk_sel, addr.fld.offset, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_count(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: TCP_RX_WC is %0d, expected %0d", $time, got, exp);
            fail_stop();
        end
    endtask

    // --------------------------------------------------
    // drivers
    // --------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic tcp_send(input logic [7:0] data);
        @(posedge BUS_CLK);
        TCP_RX_WR   <= 1'b1;
        TCP_RX_DATA <= data;
    endtask

    task automatic end_burst();
        if (TCP_RX_WR) begin
            @(posedge BUS_CLK);
            TCP_RX_WR <= 1'b0;
        end
    endtask

    // one access, then ACK must pulse in the next cycle only
    task automatic rbcp_access(input logic we, input logic [31:0] addr,
                               input logic [7:0] data, output logic [7:0] rd);
        end_burst();
        @(posedge BUS_CLK);
        RBCP_ACT  <= 1'b1;
        RBCP_WE   <= we;
        RBCP_RE   <= !we;
        RBCP_ADDR <= addr;
        RBCP_WD   <= data;
        @(negedge BUS_CLK);
        rd = RBCP_RD;
        check_flag("RBCP_ACK", RBCP_ACK, 1'b0);
        @(posedge BUS_CLK);
        RBCP_ACT <= 1'b0;
        RBCP_WE  <= 1'b0;
        RBCP_RE  <= 1'b0;
        @(negedge BUS_CLK);
        check_flag("RBCP_ACK", RBCP_ACK, 1'b1);
        @(negedge BUS_CLK);
        check_flag("RBCP_ACK", RBCP_ACK, 1'b0);
    endtask

    task automatic send_frame(input logic [31:0] addr, input logic [31:0] n,
                              input logic [31:0] seed);
        logic [31:0] state;
        logic [7:0]  data;
        logic        valid;
        bus_addr_u   cur;
        state = seed;
        cur.word = addr;
        valid = (n <= max_frame_len) && ({1'b0, addr} + {1'b0, n} <= 33'h1_0000_0000);
        end_burst();
        tcp_send(n[7:0]);
        tcp_send(n[15:8]);
        for (int i = 0; i < 4; i++) begin
            tcp_send(addr[8*i +: 8]);
        end
        for (int i = 0; i < n; i++) begin
            state = lcg_next(state);
            data = state[23:16];
            tcp_send(data);
            if (valid && cur.fld.blk_sel == ram_block_sel) begin
                ram_model[cur.fld.offset] = data;
            end
            cur.word = cur.word + 32'd1;
        end
        @(negedge BUS_CLK);
        check_count(TCP_RX_WC, hdr_bytes + n[15:0] - 16'd1);
    endtask

    // --------------------------------------------------
    // stimulus file, counted first and then executed
    // --------------------------------------------------

    task automatic process_file(input bit execute);
        int          fd;
        int          code;
        string       op;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [7:0]  rd;
        bus_addr_u   cur;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", stim_path);
            fail_stop();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                break;
            end
            if (op[0] == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            case (op)
                "T": begin
                    code = $fscanf(fd, "%h", a);
                    if (execute) tcp_send(a[7:0]);
                    else total_cycles += 1;
                end
                "F": begin
                    code = $fscanf(fd, "%h", a);
                    if (execute) begin
                        end_burst();
                        for (int i = 0; i < a; i++) begin
                            tcp_send(8'hFF);
                        end
                        @(negedge BUS_CLK);
                        check_count(TCP_RX_WC, a[15:0] - 16'd1);
                    end else begin
                        total_cycles += a + 2;
                    end
                end
                "G": begin
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                    if (execute) send_frame(a, b, c);
                    else total_cycles += b + 8;
                end
                "W": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    if (execute) rbcp_access(1'b1, a, b[7:0], rd);
                    else total_cycles += 4;
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    if (execute) begin
                        rbcp_access(1'b0, a, 8'h00, rd);
                        cur.word = a;
                        check_byte(cur, rd, b[7:0]);
                    end else begin
                        total_cycles += 4;
                    end
                end
                "M": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    if (execute) begin
                        for (int i = 0; i < b; i++) begin
                            cur.word = a + i;
                            rbcp_access(1'b0, cur.word, 8'h00, rd);
                            check_byte(cur, rd, ram_model[cur.fld.offset]);
                        end
                    end else begin
                        total_cycles += 4 * b;
                    end
                end
                "I": begin
                    code = $fscanf(fd, "%h", a);
                    if (execute) begin
                        end_burst();
                        @(posedge BUS_CLK);
                        @(negedge BUS_CLK);
                        check_flag("INVALID", INVALID, a[0]);
                    end else begin
                        total_cycles += 3;
                    end
                end
                "C": begin
                    if (execute) begin
                        end_burst();
                        @(posedge BUS_CLK);
                        @(negedge BUS_CLK);
                        check_count(TCP_RX_WC, 16'd0);
                    end else begin
                        total_cycles += 3;
                    end
                end
                default: begin
                    $display("unknown operation %s in the stimulus file", op);
                    fail_stop();
                end
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        wait (watchdog_armed);
        #((total_cycles * 4 + 200) * 20);
        $display("timeout: test did not finish");
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        BUS_RST     = 1'b1;
        TCP_RX_WR   = 1'b0;
        TCP_RX_DATA = 8'h00;
        RBCP_ACT    = 1'b0;
        RBCP_ADDR   = 32'h0;
        RBCP_WD     = 8'h00;
        RBCP_WE     = 1'b0;
        RBCP_RE     = 1'b0;
        total_cycles = 8;
        process_file(1'b0);
        watchdog_armed = 1'b1;
        repeat (4) @(posedge BUS_CLK);
        BUS_RST <= 1'b0;
        process_file(1'b1);
        end_burst();
        repeat (2) @(posedge BUS_CLK);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/bus_stim.txt */
# op and hex arguments: T byte | F count | G addr len seed | W addr data | R addr expected
# M addr count (reads checked against the RAM model) | I level | C (counter back to 0)
G 00001000 20 1b46
C
M 00001000 20
R 00000000 a5
W 00000001 11
W 00000006 66
W 00000000 77
R 00000000 a5
R 00000001 11
R 00000006 66
R 00000003 00
R 00000007 03
W 00000003 33
R 00000003 33
R 00000007 04
# length 65530 is over the limit
T fa
T ff
T 00
T 10
T 00
T 00
T 5a
I 1
C
M 00001000 1
F ffff
I 0
G 00001000 8 0007
C
M 00001000 8
# start address plus length runs past the 32-bit space
T 10
T 00
T f8
T ff
T ff
T ff
I 1
F ffff
I 0
G 00001080 4 1b46
C
M 00001080 4

/* bus_subsystem.f */
design/bus_pkg.sv
design/tcp_to_bus.sv
design/bus_reg_file.sv
design/bus_ram.sv
design/bus_subsystem.sv
tests/tb_bus_subsystem.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_bus_subsystem
FILELIST  = bus_subsystem.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) tests/bus_stim.txt

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
